/* compile.f */
logic/cacheGeomPkg.sv
logic/cacheCmdPkg.sv
logic/tagCam.sv
logic/matchEncoder.sv
logic/lineStore.sv
logic/camCacheTop.sv
dv/camCache_assertions.sv
dv/camCacheTb.sv

/* dv/camCacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module camCacheTb;

    import cacheGeomPkg::*;
    import cacheCmdPkg::*;

    localparam int settleCycles = 10;

    logic  CLK;
    logic  rst;
    logic  enable;
    cmdT   cmd;
    indexT writeIndex;
    tagT   tag;
    lineT  writeLine;
    logic  hit;
    lineT  line;

    // reference model of the cache contents.
    tagT  refTag   [numEntries];
    lineT refLine  [numEntries];
    logic refValid [numEntries];

    // hit and line hold these values until the next enabled lookup.
    logic lastHit;
    lineT lastLine;

    camCacheTop uut (
        .CLK        (CLK),
        .rst        (rst),
        .enable     (enable),
        .cmd        (cmd),
        .writeIndex (writeIndex),
        .tag        (tag),
        .writeLine  (writeLine),
        .hit        (hit),
        .line       (line)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkHit(input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch hit: got %h, expected %h", actual, expected));
        end
    endtask

    task automatic checkLine(input lineT actual, input lineT expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch line: got %h, expected %h", actual, expected));
        end
    endtask

    function automatic lineT randomLine();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // a random tag that no valid entry of the model holds.
    function automatic tagT freshTag();
        tagT  candidate;
        logic taken;
        do begin
            candidate = tagT'($urandom());
            taken = 1'b0;
            for (int i = 0; i < numEntries; i++) begin
                if (refValid[i] && refTag[i] == candidate) begin
                    taken = 1'b1;
                end
            end
        end while (taken);
        return candidate;
    endfunction

    // the lowest valid entry holding the key wins; a miss reads as zero.
    task automatic expectLookup(input tagT key, output logic expHit, output lineT expLine);
        expHit  = 1'b0;
        expLine = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (!expHit && refValid[i] && refTag[i] == key) begin
                expHit  = 1'b1;
                expLine = refLine[i];
            end
        end
    endtask

    // reset spans three rising edges and releases on the falling edge after them.
    task automatic resetDut();
        rst    = 1'b1;
        enable = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        for (int i = 0; i < numEntries; i++) begin
            refValid[i] = 1'b0;
        end
        lastHit  = 1'b0;
        lastLine = '0;
    endtask

    // all command tasks start and end on a falling edge.
    task automatic writeEntry(input indexT index, input tagT key, input lineT data);
        enable     = 1'b1;
        cmd        = cmdWrite;
        writeIndex = index;
        tag        = key;
        writeLine  = data;
        @(negedge CLK);
        enable          = 1'b0;
        refTag[index]   = key;
        refLine[index]  = data;
        refValid[index] = 1'b1;
        lastHit         = 1'b0;
        checkHit(hit, lastHit);
        checkLine(line, lastLine);
    endtask

    task automatic lookupTag(input tagT key);
        enable = 1'b1;
        cmd    = cmdLookup;
        tag    = key;
        @(negedge CLK);
        enable = 1'b0;
        expectLookup(key, lastHit, lastLine);
        checkHit(hit, lastHit);
        checkLine(line, lastLine);
    endtask

    task automatic testReset();
        int  cycles;
        tagT keptTag;
        cycles = 0;
        while (hit !== 1'b0 || line !== '0) begin
            if (cycles == settleCycles) begin
                failRun("hit and line did not clear after reset");
            end
            @(negedge CLK);
            cycles++;
        end
        // a stored entry and a registered hit must both be gone after a reset.
        keptTag = freshTag();
        writeEntry(indexT'(5), keptTag, randomLine());
        lookupTag(keptTag);
        resetDut();
        checkHit(hit, lastHit);
        checkLine(line, lastLine);
        lookupTag(keptTag);
        lookupTag(tagT'($urandom()));
    endtask

    task automatic testFillAll();
        indexT order [numEntries];
        indexT held;
        int    pick;
        for (int i = 0; i < numEntries; i++) begin
            writeEntry(indexT'(i), freshTag(), randomLine());
            order[i] = indexT'(i);
        end
        for (int i = numEntries - 1; i > 0; i--) begin
            pick        = int'($urandom_range(i, 0));
            held        = order[i];
            order[i]    = order[pick];
            order[pick] = held;
        end
        foreach (order[i]) begin
            lookupTag(refTag[order[i]]);
        end
    endtask

    task automatic testDuplicateTag();
        tagT dupTag;
        dupTag = freshTag();
        writeEntry(indexT'(40), dupTag, randomLine());
        writeEntry(indexT'(17), dupTag, randomLine());
        lookupTag(dupTag);
    endtask

    task automatic testOverwrite();
        tagT oldTag;
        tagT newTag;
        oldTag = refTag[10];
        newTag = freshTag();
        writeEntry(indexT'(10), newTag, randomLine());
        lookupTag(oldTag);
        lookupTag(newTag);
    endtask

    task automatic testEnableLow();
        tagT keptTag;
        tagT ghostTag;
        keptTag  = refTag[3];
        ghostTag = freshTag();
        lookupTag(keptTag);
        enable     = 1'b0;
        cmd        = cmdWrite;
        writeIndex = indexT'(3);
        tag        = ghostTag;
        writeLine  = randomLine();
        @(negedge CLK);
        checkHit(hit, lastHit);
        checkLine(line, lastLine);
        cmd = cmdLookup;
        @(negedge CLK);
        checkHit(hit, lastHit);
        checkLine(line, lastLine);
        lookupTag(ghostTag);
        lookupTag(keptTag);
    endtask

    initial begin
        void'($urandom(32'hfc5e_cda8));
        rst        = 1'b1;
        enable     = 1'b0;
        cmd        = cmdWrite;
        writeIndex = '0;
        tag        = '0;
        writeLine  = '0;
        lastHit    = 1'b0;
        lastLine   = '0;
        for (int i = 0; i < numEntries; i++) begin
            refTag[i]   = '0;
            refLine[i]  = '0;
            refValid[i] = 1'b0;
        end
        resetDut();

        testReset();
        testFillAll();
        lookupTag(freshTag());
        testDuplicateTag();
        testOverwrite();
        testEnableLow();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/camCache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module camCacheAssertions (
    input logic               CLK,
    input logic               rst,
    input logic               enable,
    input cacheCmdPkg::cmdT   cmd,
    input logic               hit,
    input cacheGeomPkg::lineT line
);

    import cacheGeomPkg::*;
    import cacheCmdPkg::*;

    hitLowAfterReset: assert property (@(posedge CLK) rst |=> !hit)
        else $error("hit is high in the cycle after reset");

    // a write never reports a hit.
    hitLowAfterWrite: assert property (@(posedge CLK) (enable && cmd == cmdWrite) |=> !hit)
        else $error("hit is high in the cycle after a write");

    missGivesZeroLine: assert property (
        @(posedge CLK) (!rst && enable && cmd == cmdLookup) |=> (hit || line == '0))
        else $error("line is not zero after a lookup that missed");

endmodule

bind camCacheTop camCacheAssertions camCacheChecks (
    .CLK    (CLK),
    .rst    (rst),
    .enable (enable),
    .cmd    (cmd),
    .hit    (hit),
    .line   (line)
);

`default_nettype wire

/* logic/cacheCmdPkg.sv */
`default_nettype none

package cacheCmdPkg;

    // a write stores a tag and a line at the given index,
    // a lookup compares the tag against all valid entries.
    typedef enum logic [0:0] {
        cmdWrite  = 1'b0,
        cmdLookup = 1'b1
    } cmdT;

endpackage

`default_nettype wire

/* logic/cacheGeomPkg.sv */
`default_nettype none

package cacheGeomPkg;

    // number of entries in the tag CAM and in the line store.
    localparam int numEntries = 64;

    // width of the tag compared against every entry.
    localparam int tagWidth = 16;

    // one data line per entry.
    localparam int lineWidth = 128;

    localparam int indexWidth = $clog2(numEntries);

    typedef logic [tagWidth-1:0] tagT;

    typedef logic [indexWidth-1:0] indexT;

    typedef logic [lineWidth-1:0] lineT;

    // one bit per entry, used for the valid and match vectors.
    typedef logic [numEntries-1:0] entryMaskT;

endpackage

`default_nettype wire

/* logic/camCacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module camCacheTop (
    input  logic                CLK,
    input  logic                rst,
    input  logic                enable,
    input  cacheCmdPkg::cmdT    cmd,
    input  cacheGeomPkg::indexT writeIndex,
    input  cacheGeomPkg::tagT   tag,
    input  cacheGeomPkg::lineT  writeLine,
    output logic                hit,
    output cacheGeomPkg::lineT  line
);

    import cacheGeomPkg::*;

    entryMaskT matchVec;
    indexT     matchIndex;
    logic      matchAny;

    tagCam tagCamInst (
        .CLK        (CLK),
        .rst        (rst),
        .enable     (enable),
        .cmd        (cmd),
        .writeIndex (writeIndex),
        .tag        (tag),
        .matchVec   (matchVec)
    );

    matchEncoder matchEncoderInst (
        .matchVec   (matchVec),
        .matchIndex (matchIndex),
        .matchAny   (matchAny)
    );

    // the line store is addressed by writeIndex on writes and by the encoded
    // match on lookups.
    lineStore lineStoreInst (
        .CLK        (CLK),
        .rst        (rst),
        .enable     (enable),
        .cmd        (cmd),
        .writeIndex (writeIndex),
        .writeLine  (writeLine),
        .matchIndex (matchIndex),
        .matchAny   (matchAny),
        .hit        (hit),
        .line       (line)
    );

endmodule

`default_nettype wire

/* logic/lineStore.sv */
`timescale 1ns/1ps
`default_nettype none

module lineStore (
    input  logic                CLK,
    input  logic                rst,
    input  logic                enable,
    input  cacheCmdPkg::cmdT    cmd,
    input  cacheGeomPkg::indexT writeIndex,
    input  cacheGeomPkg::lineT  writeLine,
    input  cacheGeomPkg::indexT matchIndex,
    input  logic                matchAny,
    output logic                hit,
    output cacheGeomPkg::lineT  line
);

    import cacheGeomPkg::*;
    import cacheCmdPkg::*;

    lineT  memArray [numEntries];
    indexT memAddr;
    lineT  readLine;
    logic  writeEn;
    logic  lookupEn;

    assign writeEn  = enable && (cmd == cmdWrite);
    assign lookupEn = enable && (cmd == cmdLookup);

    // the write path and the lookup path share the single memory address.
    // Only one command arrives per cycle, so the command alone picks the owner.
    assign memAddr = (cmd == cmdWrite) ? writeIndex : matchIndex;

    always_ff @(posedge CLK) begin
        if (writeEn) begin
            memArray[memAddr] <= writeLine;
        end
    end

    // a miss returns a defined all-zero line.
    assign readLine = matchAny ? memArray[memAddr] : '0;

    // results hold until the next enabled lookup.
    // A write only drops hit, leaving the last line in place.
    always_ff @(posedge CLK) begin
        if (rst) begin
            hit  <= 1'b0;
            line <= '0;
        end else if (lookupEn) begin
            hit  <= matchAny;
            line <= readLine;
        end else if (writeEn) begin
            hit <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/matchEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

module matchEncoder (
    input  cacheGeomPkg::entryMaskT matchVec,
    output cacheGeomPkg::indexT     matchIndex,
    output logic                    matchAny
);

    import cacheGeomPkg::*;

    // scan from the top entry down so that the lowest set bit is the last
    // one assigned. Several entries may hold the same tag, and the lowest
    // index always wins.
    always_comb begin
        matchIndex = '0;
        for (int i = numEntries - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                matchIndex = indexT'(i);
            end
        end
    end

    // matchIndex reads zero on a miss, so this flag tells a miss from entry 0.
    assign matchAny = |matchVec;

endmodule

`default_nettype wire

/* logic/tagCam.sv */
`timescale 1ns/1ps
`default_nettype none

module tagCam (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    enable,
    input  cacheCmdPkg::cmdT        cmd,
    input  cacheGeomPkg::indexT     writeIndex,
    input  cacheGeomPkg::tagT       tag,
    output cacheGeomPkg::entryMaskT matchVec
);

    import cacheGeomPkg::*;
    import cacheCmdPkg::*;

    entryMaskT validVec;
    entryMaskT writeSel;
    logic      writeEn;

    assign writeEn = enable && (cmd == cmdWrite);

    // one-hot decode of the write index, all zero when no write is taken.
    always_comb begin
        writeSel = '0;
        writeSel[writeIndex] = writeEn;
    end

    // an entry becomes valid on its first write and stays valid until reset.
    always_ff @(posedge CLK) begin
        if (rst) begin
            validVec <= '0;
        end else begin
            validVec <= validVec | writeSel;
        end
    end

    // each entry holds its own tag and compares it with the presented tag.
    // The compare runs every cycle; the line store decides whether it is used.
    for (genvar i = 0; i < numEntries; i++) begin : gEntry
        tagT tagReg;

        always_ff @(posedge CLK) begin
            if (writeSel[i]) begin
                tagReg <= tag;
            end
        end

        assign matchVec[i] = validVec[i] && (tagReg == tag);
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module camCacheTb -o camCacheSim

status=0
./obj_dir/camCacheSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
